//--- Makefile
TOP = fetch_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) > run.log 2>&1 || true
	cat run.log
	grep -q "STATUS: PASS" run.log

clean:
	rm -rf obj_dir run.log

//--- include/fetch_settings.svh
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// First fetch address once the memory port reports reset done
`define FETCH_RESET_VECTOR 32'h0000_2000

// Instruction memory window
`define IMEM_BASE 32'h0000_2000
`define IMEM_WORDS 256

// Cycles from an accepted command to its DONE, must be 1 or more
`define IMEM_LATENCY 2

// Start-up cycles standing in for cache initialization
`define IMEM_INIT_CYCLES 4

`endif

//--- source/fetch_pkg.sv
package fetch_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0]  cache_cmd_t;
    typedef logic [3:0]  cache_resp_t;
    typedef logic [31:0] cause_t;

    // Commands from fetch to the memory port
    localparam cache_cmd_t CACHE_CMD_NONE      = 4'd0;
    localparam cache_cmd_t CACHE_CMD_EXECUTE   = 4'd1;
    localparam cache_cmd_t CACHE_CMD_FLUSH_ALL = 4'd4;

    // Responses from the memory port
    localparam cache_resp_t CACHE_RESP_IDLE        = 4'd0;
    localparam cache_resp_t CACHE_RESP_WAIT        = 4'd1;
    localparam cache_resp_t CACHE_RESP_DONE        = 4'd2;
    localparam cache_resp_t CACHE_RESP_MISALIGNED  = 4'd3;
    localparam cache_resp_t CACHE_RESP_PAGEFAULT   = 4'd4;
    localparam cache_resp_t CACHE_RESP_ACCESSFAULT = 4'd5;

    // mcause values, bit 31 marks an interrupt
    localparam cause_t CAUSE_INSTR_MISALIGNED   = 32'd0;
    localparam cause_t CAUSE_INSTR_ACCESS_FAULT = 32'd1;
    localparam cause_t CAUSE_INSTR_PAGE_FAULT   = 32'd12;
    localparam cause_t CAUSE_TIMER_IRQ          = {1'b1, 31'd7};
    localparam cause_t CAUSE_EXTERNAL_IRQ       = {1'b1, 31'd11};

    // addi x0, x0, 0
    localparam word_t INSTR_NOP = {12'h000, 5'd0, 3'b000, 5'd0, 7'b0010011};

    typedef struct packed {
        logic   valid;
        word_t  instr;
        addr_t  pc;
        logic   exc_start;
        cause_t cause;
    } f2e_t;

    typedef struct packed {
        logic  ready;
        logic  exc_start;
        logic  exc_return;
        addr_t exc_epc;
        logic  flush;
        logic  branchtaken;
        addr_t branchtarget;
    } e2f_t;

    typedef struct packed {
        logic  request;
        logic  set_pc;
        logic  exit_request;
        addr_t pc;
    } dbg_req_t;

    typedef struct packed {
        logic timer;
        logic external;
    } irq_t;

endpackage

//--- source/fetch_top.sv
`timescale 1ns/1ps

module fetch_top (
    input  logic                 clk,
    input  logic                 reseted,
    input  fetch_pkg::e2f_t      e2f,
    input  fetch_pkg::dbg_req_t  dbg,
    input  fetch_pkg::irq_t      irq,
    input  fetch_pkg::addr_t     mtvec,
    input  logic                 load_we,
    input  fetch_pkg::addr_t     load_addr,
    input  fetch_pkg::word_t     load_data,
    output fetch_pkg::f2e_t      f2e,
    output logic                 dbg_mode,
    output logic                 dbg_done
);
    import fetch_pkg::*;

    // Fetch to memory port
    cache_cmd_t  c_cmd;
    addr_t       c_address;
    cache_resp_t c_response;
    word_t       c_load_data;
    logic        c_reset_done;

    fetch_unit fetch_unit_i (
        .clk          (clk),
        .reseted      (reseted),
        .mtvec        (mtvec),
        .irq          (irq),
        .e2f          (e2f),
        .dbg          (dbg),
        .c_response   (c_response),
        .c_load_data  (c_load_data),
        .c_reset_done (c_reset_done),
        .c_cmd        (c_cmd),
        .c_address    (c_address),
        .f2e          (f2e),
        .dbg_mode     (dbg_mode),
        .dbg_done     (dbg_done)
    );

    imem_port imem_port_i (
        .clk          (clk),
        .reseted      (reseted),
        .c_cmd        (c_cmd),
        .c_address    (c_address),
        .load_we      (load_we),
        .load_addr    (load_addr),
        .load_data    (load_data),
        .c_response   (c_response),
        .c_load_data  (c_load_data),
        .c_reset_done (c_reset_done)
    );

endmodule

//--- source/fetch_unit.sv
`timescale 1ns/1ps
`include "fetch_settings.svh"

module fetch_unit (
    input  logic                   clk,
    input  logic                   reseted,
    input  fetch_pkg::addr_t       mtvec,
    input  fetch_pkg::irq_t        irq,
    input  fetch_pkg::e2f_t        e2f,
    input  fetch_pkg::dbg_req_t    dbg,
    input  fetch_pkg::cache_resp_t c_response,
    input  fetch_pkg::word_t       c_load_data,
    input  logic                   c_reset_done,
    output fetch_pkg::cache_cmd_t  c_cmd,
    output fetch_pkg::addr_t       c_address,
    output fetch_pkg::f2e_t        f2e,
    output logic                   dbg_mode,
    output logic                   dbg_done
);
    import fetch_pkg::*;

    addr_t  pc;
    addr_t  next_pc;
    word_t  saved_instr;
    word_t  fetched;
    cause_t cause;

    logic just_reset;
    logic flushing;
    logic after_flush;

    logic resp_done;
    logic resp_wait;
    logic resp_idle;
    logic resp_fault;
    logic dbg_exit;
    logic decide;
    logic enter_dbg;
    logic start_flush;
    logic dbg_load;
    logic exc_start;
    logic show;

    assign resp_done  = (c_response == CACHE_RESP_DONE);
    assign resp_wait  = (c_response == CACHE_RESP_WAIT);
    assign resp_idle  = (c_response == CACHE_RESP_IDLE);
    assign resp_fault = (c_response == CACHE_RESP_MISALIGNED) ||
                        (c_response == CACHE_RESP_ACCESSFAULT) ||
                        (c_response == CACHE_RESP_PAGEFAULT);
    assign dbg_exit   = dbg_mode && dbg.exit_request;

    assign c_address = next_pc;

    // Fault codes win over interrupts, external over timer
    always_comb begin
        cause = '0;
        if (c_response == CACHE_RESP_MISALIGNED) begin
            cause = CAUSE_INSTR_MISALIGNED;
        end else if (c_response == CACHE_RESP_ACCESSFAULT) begin
            cause = CAUSE_INSTR_ACCESS_FAULT;
        end else if (c_response == CACHE_RESP_PAGEFAULT) begin
            cause = CAUSE_INSTR_PAGE_FAULT;
        end else if (irq.external) begin
            cause = CAUSE_EXTERNAL_IRQ;
        end else if (irq.timer) begin
            cause = CAUSE_TIMER_IRQ;
        end
    end

    // Command and next address
    always_comb begin
        next_pc     = pc;
        c_cmd       = CACHE_CMD_NONE;
        exc_start   = 1'b0;
        decide      = 1'b0;
        enter_dbg   = 1'b0;
        start_flush = 1'b0;
        dbg_load    = 1'b0;
        if (c_reset_done) begin
            if (dbg_mode && !dbg.exit_request) begin
                // Halted, only the debug PC may change
                if (dbg.set_pc) begin
                    next_pc  = dbg.pc;
                    dbg_load = 1'b1;
                end
            end else if (flushing) begin
                if (!resp_done) begin
                    c_cmd = CACHE_CMD_FLUSH_ALL;
                end
            end else if (resp_wait) begin
                // Repeat the outstanding fetch
                c_cmd = CACHE_CMD_EXECUTE;
            end else if (just_reset || dbg_exit || resp_fault ||
                         (e2f.ready && (resp_done || resp_idle))) begin
                decide = 1'b1;
                c_cmd  = CACHE_CMD_EXECUTE;
                if (just_reset) begin
                    next_pc = `FETCH_RESET_VECTOR;
                end else if (dbg.request) begin
                    // Park on the address after the last consumed instruction
                    c_cmd     = CACHE_CMD_NONE;
                    enter_dbg = 1'b1;
                    next_pc   = pc + 32'd4;
                end else if (irq.external || irq.timer) begin
                    exc_start = 1'b1;
                    next_pc   = mtvec;
                end else if (e2f.exc_return) begin
                    next_pc = e2f.exc_epc;
                end else if (e2f.branchtaken) begin
                    next_pc = e2f.branchtarget;
                end else if (e2f.ready && e2f.flush) begin
                    c_cmd       = CACHE_CMD_FLUSH_ALL;
                    start_flush = 1'b1;
                end else if (e2f.ready && e2f.exc_start) begin
                    next_pc = mtvec;
                end else if (resp_fault) begin
                    exc_start = 1'b1;
                    next_pc   = mtvec;
                end else begin
                    // Debug exit resumes at the parked or loaded PC
                    next_pc = dbg_exit ? pc : pc + 32'd4;
                end
            end
        end
    end

    // Instruction towards execute
    always_comb begin
        show    = 1'b0;
        fetched = INSTR_NOP;
        if (c_reset_done && !dbg_mode && !just_reset) begin
            if (resp_done && !flushing) begin
                show    = 1'b1;
                fetched = c_load_data;
            end else if (resp_idle && !after_flush) begin
                // Held by back-pressure
                show    = 1'b1;
                fetched = saved_instr;
            end
        end
        f2e.valid     = show && !exc_start;
        f2e.instr     = f2e.valid ? fetched : INSTR_NOP;
        f2e.pc        = pc;
        f2e.exc_start = exc_start;
        f2e.cause     = cause;
    end

    always_ff @(posedge clk) begin
        if (resp_done && !flushing) begin
            saved_instr <= c_load_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reseted) begin
            pc          <= `FETCH_RESET_VECTOR;
            just_reset  <= 1'b1;
            flushing    <= 1'b0;
            after_flush <= 1'b0;
            dbg_mode    <= 1'b0;
            dbg_done    <= 1'b0;
        end else begin
            pc       <= next_pc;
            dbg_done <= dbg_load;
            if (flushing && resp_done) begin
                flushing    <= 1'b0;
                after_flush <= 1'b1;
            end
            if (decide) begin
                just_reset  <= 1'b0;
                after_flush <= 1'b0;
                dbg_mode    <= enter_dbg;
                flushing    <= start_flush;
            end
        end
    end

    // Memory port sees a stable request until it answers
    a_wait_hold: assert property (@(posedge clk) disable iff (reseted)
        c_response == CACHE_RESP_WAIT |->
            (c_cmd == $past(c_cmd)) && (c_address == $past(c_address)));

endmodule

//--- source/imem_port.sv
`timescale 1ns/1ps
`include "fetch_settings.svh"

module imem_port (
    input  logic                   clk,
    input  logic                   reseted,
    input  fetch_pkg::cache_cmd_t  c_cmd,
    input  fetch_pkg::addr_t       c_address,
    input  logic                   load_we,
    input  fetch_pkg::addr_t       load_addr,
    input  fetch_pkg::word_t       load_data,
    output fetch_pkg::cache_resp_t c_response,
    output fetch_pkg::word_t       c_load_data,
    output logic                   c_reset_done
);
    import fetch_pkg::*;

    localparam int         INDEX_W    = $clog2(`IMEM_WORDS);
    localparam addr_t      WINDOW_LO  = `IMEM_BASE;
    localparam addr_t      WINDOW_HI  = `IMEM_BASE + 4 * `IMEM_WORDS;
    localparam logic [7:0] INIT_LAST  = 8'(`IMEM_INIT_CYCLES - 1);
    localparam logic [7:0] LAST_WAIT  = 8'(`IMEM_LATENCY - 1);

    typedef enum logic [1:0] {
        INIT,
        IDLE,
        BUSY
    } seq_state_t;

    seq_state_t  state;
    logic [7:0]  count;
    word_t       mem [`IMEM_WORDS];
    cache_cmd_t  cmd_q;
    addr_t       addr_q;
    cache_cmd_t  cur_cmd;
    addr_t       cur_addr;
    cache_resp_t fin_resp;
    logic        accept;
    logic        finish;

    function automatic logic in_window(addr_t a);
        return (a >= WINDOW_LO) && (a < WINDOW_HI);
    endfunction

    function automatic logic [INDEX_W-1:0] word_index(addr_t a);
        addr_t offset;
        offset = a - WINDOW_LO;
        return offset[INDEX_W+1:2];
    endfunction

    assign accept = (state == IDLE) && (c_cmd != CACHE_CMD_NONE);

    // Request being answered, straight from the bus at single-cycle latency
    assign cur_cmd  = (state == BUSY) ? cmd_q : c_cmd;
    assign cur_addr = (state == BUSY) ? addr_q : c_address;

    assign finish = (accept && (`IMEM_LATENCY == 1)) ||
                    ((state == BUSY) && (count == LAST_WAIT));

    // Alignment before range
    always_comb begin
        fin_resp = CACHE_RESP_DONE;
        if (cur_cmd == CACHE_CMD_EXECUTE) begin
            if (cur_addr[1:0] != 2'b00) begin
                fin_resp = CACHE_RESP_MISALIGNED;
            end else if (!in_window(cur_addr)) begin
                fin_resp = CACHE_RESP_ACCESSFAULT;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reseted) begin
            state        <= INIT;
            count        <= '0;
            c_reset_done <= 1'b0;
            c_response   <= CACHE_RESP_IDLE;
        end else begin
            case (state)
                INIT: begin
                    if (count == INIT_LAST) begin
                        state        <= IDLE;
                        count        <= '0;
                        c_reset_done <= 1'b1;
                    end else begin
                        count <= count + 8'd1;
                    end
                end
                IDLE: begin
                    if (finish) begin
                        c_response <= fin_resp;
                    end else if (accept) begin
                        state      <= BUSY;
                        count      <= 8'd1;
                        c_response <= CACHE_RESP_WAIT;
                    end else begin
                        c_response <= CACHE_RESP_IDLE;
                    end
                end
                BUSY: begin
                    if (finish) begin
                        state      <= IDLE;
                        c_response <= fin_resp;
                    end else begin
                        count      <= count + 8'd1;
                        c_response <= CACHE_RESP_WAIT;
                    end
                end
                default: state <= INIT;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            cmd_q  <= c_cmd;
            addr_q <= c_address;
        end
        if (finish && (fin_resp == CACHE_RESP_DONE) && (cur_cmd == CACHE_CMD_EXECUTE)) begin
            c_load_data <= mem[word_index(cur_addr)];
        end
        // Boot load, blocked while a fetch is in progress
        if (load_we && (state != BUSY) && in_window(load_addr)) begin
            mem[word_index(load_addr)] <= load_data;
        end
    end

    a_no_cmd_in_init: assert property (@(posedge clk) disable iff (reseted)
        !c_reset_done |-> c_cmd == CACHE_CMD_NONE);

endmodule

//--- sources.f
+incdir+include
source/fetch_pkg.sv
source/fetch_unit.sv
source/imem_port.sv
source/fetch_top.sv
tests/fetch_tb_clock.sv
tests/fetch_tb.sv

//--- tests/fetch_tb.sv
`timescale 1ns/1ps
`include "fetch_settings.svh"

module fetch_tb;
    import fetch_pkg::*;

    localparam int    LIMIT    = 40;
    localparam int    NUM_ROWS = 14;
    localparam addr_t MTVEC    = 32'h0000_2300;

    typedef enum logic [2:0] {
        ACT_STALL, ACT_RUN, ACT_BRANCH, ACT_ERET, ACT_IRQ, ACT_FAULT, ACT_FLUSH, ACT_DEBUG
    } act_t;

    typedef struct packed {
        act_t   act;
        addr_t  operand;
        addr_t  exp_pc;
        cause_t exp_cause;
    } row_t;

    // Operand is a cycle count, an instruction count, a target or the irq lines
    localparam row_t ROWS [NUM_ROWS] = '{
        '{ACT_STALL,  32'd3,         32'h0000_2000, 32'd0},
        '{ACT_RUN,    32'd5,         32'h0000_2004, 32'd0},
        '{ACT_BRANCH, 32'h0000_2080, 32'h0000_2080, 32'd0},
        '{ACT_RUN,    32'd3,         32'h0000_2084, 32'd0},
        '{ACT_STALL,  32'd4,         32'h0000_2090, 32'd0},
        '{ACT_ERET,   32'h0000_2040, 32'h0000_2040, 32'd0},
        '{ACT_IRQ,    32'd2,         MTVEC,         CAUSE_TIMER_IRQ},
        '{ACT_RUN,    32'd2,         32'h0000_2304, 32'd0},
        '{ACT_IRQ,    32'd3,         MTVEC,         CAUSE_EXTERNAL_IRQ},
        '{ACT_FAULT,  32'h0000_2042, MTVEC,         CAUSE_INSTR_MISALIGNED},
        '{ACT_FAULT,  32'h0000_3000, MTVEC,         CAUSE_INSTR_ACCESS_FAULT},
        '{ACT_FLUSH,  32'd0,         32'h0000_2308, 32'd0},
        '{ACT_DEBUG,  32'h0000_2200, 32'h0000_2200, 32'd0},
        '{ACT_RUN,    32'd4,         32'h0000_2204, 32'd0}
    };

    logic     clk;
    logic     reseted;
    e2f_t     e2f;
    dbg_req_t dbg;
    irq_t     irq;
    addr_t    mtvec;
    logic     load_we;
    addr_t    load_addr;
    word_t    load_data;
    f2e_t     f2e;
    logic     dbg_mode;
    logic     dbg_done;

    word_t       model [`IMEM_WORDS];
    addr_t       exp_next;
    row_t        row;
    word_t       w;
    logic [15:0] lfsr;

    fetch_tb_clock clock_i (.clk(clk), .reseted(reseted));

    fetch_top dut_i (
        .clk       (clk),
        .reseted   (reseted),
        .e2f       (e2f),
        .dbg       (dbg),
        .irq       (irq),
        .mtvec     (mtvec),
        .load_we   (load_we),
        .load_addr (load_addr),
        .load_data (load_data),
        .f2e       (f2e),
        .dbg_mode  (dbg_mode),
        .dbg_done  (dbg_done)
    );

    // Taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // Word that load_word placed at this address
    function automatic word_t expected_instr(input addr_t a);
        for (int i = 0; i < `IMEM_WORDS; i++) begin
            if (`IMEM_BASE + 32'(4 * i) == a) begin
                return model[i];
            end
        end
        return 'x;
    endfunction

    task automatic abort_run();
        $display("STATUS: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic report(input string name, input logic [31:0] got, input logic [31:0] exp);
        $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
        abort_run();
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) report(name, got, exp);
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) report(name, got, exp);
    endtask

    task automatic check_cause(input string name, input cause_t got, input cause_t exp);
        if (got !== exp) report(name, got, exp);
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) report(name, 32'(got), 32'(exp));
    endtask

    function automatic logic probe(input string name);
        case (name)
            "f2e.valid":     return f2e.valid;
            "f2e.exc_start": return f2e.exc_start;
            "dbg_done":      return dbg_done;
            default:         return dbg_mode;
        endcase
    endfunction

    // Steps falling edges until the named output is high
    task automatic wait_high(input string name);
        int n;
        n = 0;
        @(negedge clk);
        while (probe(name) !== 1'b1) begin
            n++;
            if (n > LIMIT) begin
                $display("Timeout: %s stayed low for %0d cycles", name, LIMIT);
                abort_run();
            end
            @(negedge clk);
        end
    endtask

    // Execute takes one instruction, ready is high
    task automatic consume(input addr_t exp_pc);
        wait_high("f2e.valid");
        check_addr("f2e.pc", f2e.pc, exp_pc);
        check_word("f2e.instr", f2e.instr, expected_instr(exp_pc));
        check_bit("dbg_mode", dbg_mode, 1'b0);
    endtask

    task automatic load_word(input int i);
        load_we   <= 1'b1;
        load_addr <= `IMEM_BASE + 32'(4 * i);
        load_data <= model[i];
    endtask

    initial begin
        e2f         <= '0;
        dbg         <= '0;
        irq         <= '0;
        mtvec       <= MTVEC;
        load_we     <= 1'b0;
        load_addr   <= '0;
        load_data   <= '0;
        lfsr        = 16'd20368;
        for (int i = 0; i < `IMEM_WORDS; i++) begin
            w = '0;
            for (int b = 0; b < 32; b++) begin
                lfsr = lfsr_step(lfsr);
                w    = {w[30:0], lfsr[0]};
            end
            model[i] = (w == INSTR_NOP) ? ~w : w;
        end
        // First words go in while the port is still in reset
        for (int i = 0; i < 8; i++) begin
            @(posedge clk);
            load_word(i);
        end
        @(posedge clk);
        load_we <= 1'b0;
        @(negedge clk);
        check_bit("dbg_mode", dbg_mode, 1'b0);
        check_bit("f2e.valid", f2e.valid, 1'b0);
        check_bit("f2e.exc_start", f2e.exc_start, 1'b0);
        // With ready low the port idles after the first fetch
        wait_high("f2e.valid");
        for (int i = 8; i < `IMEM_WORDS; i++) begin
            @(posedge clk);
            load_word(i);
        end
        @(posedge clk);
        load_we  <= 1'b0;
        exp_next = `FETCH_RESET_VECTOR;

        for (int r = 0; r < NUM_ROWS; r++) begin
            row = ROWS[r];
            @(posedge clk);
            e2f.ready <= (row.act != ACT_STALL);
            case (row.act)
                ACT_STALL: begin
                    wait_high("f2e.valid");
                    repeat (row.operand + 1) begin
                        check_bit("f2e.valid", f2e.valid, 1'b1);
                        check_addr("f2e.pc", f2e.pc, row.exp_pc);
                        check_word("f2e.instr", f2e.instr, expected_instr(row.exp_pc));
                        @(negedge clk);
                    end
                    @(posedge clk);
                    e2f.ready <= 1'b1;
                    consume(row.exp_pc);
                end
                ACT_RUN: begin
                    for (int n = 0; n < int'(row.operand); n++) begin
                        consume(row.exp_pc + 32'(4 * n));
                    end
                end
                ACT_BRANCH, ACT_FAULT: begin
                    e2f.branchtaken  <= 1'b1;
                    e2f.branchtarget <= row.operand;
                    consume(exp_next);
                    @(posedge clk);
                    e2f.branchtaken <= 1'b0;
                    if (row.act == ACT_FAULT) begin
                        wait_high("f2e.exc_start");
                        check_bit("f2e.valid", f2e.valid, 1'b0);
                        check_addr("f2e.pc", f2e.pc, row.operand);
                        check_cause("f2e.cause", f2e.cause, row.exp_cause);
                    end
                    consume(row.exp_pc);
                end
                ACT_ERET: begin
                    e2f.exc_return <= 1'b1;
                    e2f.exc_epc    <= row.operand;
                    consume(exp_next);
                    @(posedge clk);
                    e2f.exc_return <= 1'b0;
                    consume(row.exp_pc);
                end
                ACT_IRQ: begin
                    irq <= row.operand[1:0];
                    wait_high("f2e.exc_start");
                    check_bit("f2e.valid", f2e.valid, 1'b0);
                    check_addr("f2e.pc", f2e.pc, exp_next);
                    check_cause("f2e.cause", f2e.cause, row.exp_cause);
                    @(posedge clk);
                    irq <= '0;
                    consume(row.exp_pc);
                end
                ACT_FLUSH: begin
                    e2f.flush <= 1'b1;
                    consume(exp_next);
                    @(posedge clk);
                    e2f.flush <= 1'b0;
                    // A stale repeat would show the flushed pc again
                    consume(row.exp_pc);
                end
                default: begin
                    dbg.request <= 1'b1;
                    consume(exp_next);
                    @(posedge clk);
                    dbg.request <= 1'b0;
                    wait_high("dbg_mode");
                    repeat (3) begin
                        check_bit("f2e.valid", f2e.valid, 1'b0);
                        @(negedge clk);
                    end
                    @(posedge clk);
                    dbg.set_pc <= 1'b1;
                    dbg.pc     <= row.operand;
                    @(posedge clk);
                    dbg.set_pc <= 1'b0;
                    wait_high("dbg_done");
                    @(negedge clk);
                    check_bit("dbg_done", dbg_done, 1'b0);
                    @(posedge clk);
                    dbg.exit_request <= 1'b1;
                    @(posedge clk);
                    dbg.exit_request <= 1'b0;
                    @(negedge clk);
                    check_bit("dbg_mode", dbg_mode, 1'b0);
                    consume(row.exp_pc);
                end
            endcase
            exp_next = (row.act == ACT_RUN) ? row.exp_pc + 4 * row.operand : row.exp_pc + 32'd4;
        end

        @(posedge clk);
        $display("STATUS: PASS");
        $finish;
    end

endmodule

//--- tests/fetch_tb_clock.sv
`timescale 1ns/1ps

module fetch_tb_clock (
    output logic clk,
    output logic reseted
);

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Reset held over the first 8 rising edges
    initial begin
        reseted <= 1'b1;
        repeat (8) @(posedge clk);
        reseted <= 1'b0;
    end

endmodule
